//--- controls_input.txt
# test_name kind fields
# S player dir(R L B N) cycles phase | G player events(U D X) gear | A left right ones_l ones_r
# Steering on player 0
s_r1       S 0 R 8  01
s_r2       S 0 R 16 10
s_r4       S 0 R 32 10
s_r7       S 0 R 7  10
s_r9       S 0 R 9  00
s_l1       S 0 L 8  10
s_l3       S 0 L 24 00
s_part_r   S 0 R 5  00
s_part_r2  S 0 R 7  00
s_both     S 0 B 12 00
s_none     S 0 N 10 00
s_after_b  S 0 R 8  01
# Steering on the other players
s_p1_l     S 1 L 8  10
s_p2_r3    S 2 R 24 10
s_p3_l2    S 3 L 16 11
s_p3_b     S 3 B 20 11
# Gear presses
g_p1_uuud  G 1 UUUD  2
g_p1_ddd   G 1 DDD   1
g_p1_x     G 1 X     1
g_p1_ux    G 1 UX    2
g_p1_top   G 1 UUUUU 3
g_p1_xd    G 1 XD    2
g_p0_uu    G 0 UU    3
g_p2_du    G 2 DU    2
g_p3_udu   G 3 UDU   2
# Audio converters with a reset before each record
a_0_127    A 0 127 0 127
a_127_0    A 127 0 127 0
a_64_1     A 64 1 64 1
a_37_100   A 37 100 37 100
a_1_126    A 1 126 1 126
a_85_85    A 85 85 85 85
# Controls after the last reset
s_post_r   S 2 R 8  01
g_post_u   G 2 U     2
s_post_l   S 1 L 16 11

//--- gearshift.sv
`timescale 1ns/1ps
/* Three-position gear selector */
module gearshift (
	input  logic clk_12,
	input  logic rst,
	input  logic gear_up,
	input  logic gear_down,
	output logic gear1,
	output logic gear2,
	output logic gear3
);

	sprint4_pkg::gear_state_t state;
	sprint4_pkg::gear_state_t state_next;
	logic up_q;
	logic down_q;
	logic up_rise;
	logic down_rise;

	// Previous button levels for edge detection
	always_ff @(posedge clk_12) begin
		if (rst) begin
			up_q   <= 1'b0;
			down_q <= 1'b0;
		end else begin
			up_q   <= gear_up;
			down_q <= gear_down;
		end
	end

	assign up_rise   = gear_up & ~up_q;
	assign down_rise = gear_down & ~down_q;

	// One step per press, saturating at both ends
	// Presses landing together cancel out
	always_comb begin
		state_next = state;
		if (up_rise && !down_rise) begin
			case (state)
				sprint4_pkg::GEAR_1: state_next = sprint4_pkg::GEAR_2;
				sprint4_pkg::GEAR_2: state_next = sprint4_pkg::GEAR_3;
				default:             state_next = sprint4_pkg::GEAR_3;
			endcase
		end else if (down_rise && !up_rise) begin
			case (state)
				sprint4_pkg::GEAR_3: state_next = sprint4_pkg::GEAR_2;
				sprint4_pkg::GEAR_2: state_next = sprint4_pkg::GEAR_1;
				default:             state_next = sprint4_pkg::GEAR_1;
			endcase
		end
	end

	always_ff @(posedge clk_12) begin
		if (rst)
			state <= sprint4_pkg::GEAR_1;
		else
			state <= state_next;
	end

	// One-hot selector lines, active high
	assign gear1 = (state == sprint4_pkg::GEAR_1);
	assign gear2 = (state == sprint4_pkg::GEAR_2);
	assign gear3 = (state == sprint4_pkg::GEAR_3);

endmodule

//--- joy2quad.sv
`timescale 1ns/1ps
/* Steering quadrature encoder */
module joy2quad (
	input  logic clk_12,
	input  logic rst,
	input  logic right,
	input  logic left,
	output logic steer_a,
	output logic steer_b
);

	sprint4_pkg::steer_cnt_t div_cnt;
	sprint4_pkg::steer_phase_t phase;
	logic one_dir;
	logic step;

	// Gray order 00, 01, 11, 10 as the wheel turns right
	function automatic sprint4_pkg::steer_phase_t phase_fwd(
		input sprint4_pkg::steer_phase_t cur
	);
		case (cur)
			2'b00: phase_fwd = 2'b01;
			2'b01: phase_fwd = 2'b11;
			2'b11: phase_fwd = 2'b10;
			default: phase_fwd = 2'b00;
		endcase
	endfunction

	// Same ring walked the other way for left
	function automatic sprint4_pkg::steer_phase_t phase_rev(
		input sprint4_pkg::steer_phase_t cur
	);
		case (cur)
			2'b00: phase_rev = 2'b10;
			2'b10: phase_rev = 2'b11;
			2'b11: phase_rev = 2'b01;
			default: phase_rev = 2'b00;
		endcase
	endfunction

	// Both or neither held means the wheel is centred
	assign one_dir = right ^ left;
	assign step = one_dir &&
		(div_cnt == sprint4_pkg::steer_cnt_t'(sprint4_pkg::STEER_DIV - 1));

	// Partial count is thrown away whenever the wheel is centred
	always_ff @(posedge clk_12) begin
		if (rst || !one_dir) begin
			div_cnt <= '0;
		end else if (step) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + sprint4_pkg::steer_cnt_t'(1);
		end
	end

	always_ff @(posedge clk_12) begin
		if (rst) begin
			phase <= 2'b00;
		end else if (step) begin
			if (right)
				phase <= phase_fwd(phase);
			else
				phase <= phase_rev(phase);
		end
	end

	// Straight from the register, so only one line moves per step
	assign steer_a = phase[1];
	assign steer_b = phase[0];

endmodule

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the result

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_sprint4_controls -f sim.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vtb_sprint4_controls)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "No errors"; then
	echo "PASS"
	exit 0
fi

echo "FAIL"
exit 1

//--- sigma_dac.sv
`timescale 1ns/1ps
/* First-order delta-sigma DAC */
module sigma_dac (
	input  logic                clk_12,
	input  logic                rst,
	input  sprint4_pkg::audio_t sample,
	output logic                dac_out
);

	// Low bits hold the running error, top bit the last carry
	logic [sprint4_pkg::AUDIO_BITS:0] acc;
	logic [sprint4_pkg::AUDIO_BITS:0] sum;

	// Previous carry is dropped before the next add
	assign sum = {1'b0, acc[sprint4_pkg::AUDIO_BITS-1:0]} + {1'b0, sample};

	always_ff @(posedge clk_12) begin
		if (rst)
			acc <= '0;
		else
			acc <= sum;
	end

	// Carry density over 128 cycles equals sample / 128
	assign dac_out = acc[sprint4_pkg::AUDIO_BITS];

endmodule

//--- sim.f
sprint4_pkg.sv
joy2quad.sv
gearshift.sv
sigma_dac.sv
sprint4_controls.sv
sprint4_controls_props.sv
tb_sprint4_controls.sv

//--- sprint4_controls.sv
`timescale 1ns/1ps
/* Sprint 4 player controls and audio */
module sprint4_controls (
	input  logic                                clk_12,
	input  logic                                rst,

	// Per-player steering levels
	input  logic [sprint4_pkg::NUM_PLAYERS-1:0] right,
	input  logic [sprint4_pkg::NUM_PLAYERS-1:0] left,

	// Per-player shifter buttons
	input  logic [sprint4_pkg::NUM_PLAYERS-1:0] gear_up,
	input  logic [sprint4_pkg::NUM_PLAYERS-1:0] gear_down,

	// Mixed audio, players 1 and 2 left, players 3 and 4 right
	input  sprint4_pkg::audio_t                 audio_l,
	input  sprint4_pkg::audio_t                 audio_r,

	// Wheel encoder phases to the game logic
	output logic [sprint4_pkg::NUM_PLAYERS-1:0] steer_a,
	output logic [sprint4_pkg::NUM_PLAYERS-1:0] steer_b,

	// Gear selector lines to the game logic
	output logic [sprint4_pkg::NUM_PLAYERS-1:0] gear1,
	output logic [sprint4_pkg::NUM_PLAYERS-1:0] gear2,
	output logic [sprint4_pkg::NUM_PLAYERS-1:0] gear3,

	// One-bit audio streams to the output pins
	output logic                                audio_out_l,
	output logic                                audio_out_r
);

	// One wheel and one shifter per cabinet position
	for (genvar p = 0; p < sprint4_pkg::NUM_PLAYERS; p++) begin : g_player

		joy2quad steer (
			.clk_12  (clk_12),
			.rst     (rst),
			.right   (right[p]),
			.left    (left[p]),
			.steer_a (steer_a[p]),
			.steer_b (steer_b[p])
		);

		gearshift gear (
			.clk_12    (clk_12),
			.rst       (rst),
			.gear_up   (gear_up[p]),
			.gear_down (gear_down[p]),
			.gear1     (gear1[p]),
			.gear2     (gear2[p]),
			.gear3     (gear3[p])
		);

	end

	// Audio converters, one per speaker channel
	sigma_dac dac_l (
		.clk_12  (clk_12),
		.rst     (rst),
		.sample  (audio_l),
		.dac_out (audio_out_l)
	);

	sigma_dac dac_r (
		.clk_12  (clk_12),
		.rst     (rst),
		.sample  (audio_r),
		.dac_out (audio_out_r)
	);

endmodule

//--- sprint4_controls_props.sv
`timescale 1ns/1ps
/* Controls block assertions */
module sprint4_controls_props (
	input logic                                clk_12,
	input logic                                rst,
	input logic [sprint4_pkg::NUM_PLAYERS-1:0] steer_a,
	input logic [sprint4_pkg::NUM_PLAYERS-1:0] steer_b,
	input logic [sprint4_pkg::NUM_PLAYERS-1:0] gear1,
	input logic [sprint4_pkg::NUM_PLAYERS-1:0] gear2,
	input logic [sprint4_pkg::NUM_PLAYERS-1:0] gear3,
	input logic                                audio_out_l,
	input logic                                audio_out_r
);

	for (genvar p = 0; p < sprint4_pkg::NUM_PLAYERS; p++) begin : g_chk

		// Exactly one selector line per shifter
		a_gear_onehot: assert property (@(posedge clk_12) disable iff (rst)
			$onehot({gear3[p], gear2[p], gear1[p]}))
			else $error("Gear lines of player %0d are not one-hot", p);

		// Quadrature outputs move one line at a time
		a_steer_gray: assert property (@(posedge clk_12) disable iff (rst)
			!((steer_a[p] != $past(steer_a[p])) && (steer_b[p] != $past(steer_b[p]))))
			else $error("Both steering phases of player %0d changed in one cycle", p);

	end

	a_reset_state: assert property (@(posedge clk_12)
		$past(rst) |-> (&gear1 && !audio_out_l && !audio_out_r))
		else $error("Gear or audio outputs not at their reset values after reset");

endmodule

bind sprint4_controls sprint4_controls_props props (.*);

//--- sprint4_pkg.sv
/* Sprint 4 controls shared definitions */
package sprint4_pkg;

	// Four cabinet positions, each with a wheel and a shifter
	localparam int NUM_PLAYERS = 4;

	// clk_12 cycles between quadrature steps while a direction is held
	// Kept small so a simulated turn is short
	localparam int STEER_DIV = 8;

	// Width of one audio channel sample from the sound mixer
	localparam int AUDIO_BITS = 7;

	// Divide counter must be able to hold STEER_DIV itself
	localparam int STEER_CNT_BITS = $clog2(STEER_DIV + 1);

	// One audio sample, full scale is 2**AUDIO_BITS - 1
	typedef logic [AUDIO_BITS-1:0] audio_t;

	// Quadrature position as the pair {steer_a, steer_b}
	typedef logic [1:0] steer_phase_t;

	// Steering divide counter
	typedef logic [STEER_CNT_BITS-1:0] steer_cnt_t;

	// Three-position gear selector
	typedef enum logic [1:0] {
		GEAR_1,
		GEAR_2,
		GEAR_3
	} gear_state_t;

endpackage

//--- tb_sprint4_controls.sv
`timescale 1ns/1ps
/* Controls block testbench */
module tb_sprint4_controls;

	logic                                clk_12;
	logic                                rst;
	logic [sprint4_pkg::NUM_PLAYERS-1:0] right;
	logic [sprint4_pkg::NUM_PLAYERS-1:0] left;
	logic [sprint4_pkg::NUM_PLAYERS-1:0] gear_up;
	logic [sprint4_pkg::NUM_PLAYERS-1:0] gear_down;
	sprint4_pkg::audio_t                 audio_l;
	sprint4_pkg::audio_t                 audio_r;
	logic [sprint4_pkg::NUM_PLAYERS-1:0] steer_a;
	logic [sprint4_pkg::NUM_PLAYERS-1:0] steer_b;
	logic [sprint4_pkg::NUM_PLAYERS-1:0] gear1;
	logic [sprint4_pkg::NUM_PLAYERS-1:0] gear2;
	logic [sprint4_pkg::NUM_PLAYERS-1:0] gear3;
	logic                                audio_out_l;
	logic                                audio_out_r;

	// Test records as read from the data file
	logic [159:0] rec_name [$];
	logic [7:0]   rec_kind [$];
	int           rec_player [$];
	logic [127:0] rec_code [$];
	int           rec_a [$];
	int           rec_b [$];
	int           rec_c [$];
	int           rec_d [$];

	// Expected steering phase and gear of every player
	sprint4_pkg::steer_phase_t exp_phase [sprint4_pkg::NUM_PLAYERS];
	int                        exp_gear [sprint4_pkg::NUM_PLAYERS];

	int test_errs;
	int pass_count;
	int fail_count;

	sprint4_controls DUT (
		.clk_12      (clk_12),
		.rst         (rst),
		.right       (right),
		.left        (left),
		.gear_up     (gear_up),
		.gear_down   (gear_down),
		.audio_l     (audio_l),
		.audio_r     (audio_r),
		.steer_a     (steer_a),
		.steer_b     (steer_b),
		.gear1       (gear1),
		.gear2       (gear2),
		.gear3       (gear3),
		.audio_out_l (audio_out_l),
		.audio_out_r (audio_out_r)
	);

	initial begin
		clk_12 = 1'b0;
		forever #4 clk_12 = ~clk_12;
	end

	// Gear number from the selector lines or 0 when they are not one-hot
	function automatic int gear_index(input logic [2:0] lines);
		case (lines)
			3'b001: return 1;
			3'b010: return 2;
			3'b100: return 3;
			default: return 0;
		endcase
	endfunction

	function automatic int event_count(input logic [127:0] code);
		int n;
		n = 0;
		for (int k = 0; k < 16; k++) begin
			if (code[8*k +: 8] != 8'h00)
				n++;
		end
		return n;
	endfunction

	// Clock cycles that one record takes to run
	function automatic int record_cycles(input int i);
		case (rec_kind[i])
			"S": return rec_a[i] + 1;
			"G": return 3 * event_count(rec_code[i]);
			"A": return 132;
			default: return 0;
		endcase
	endfunction

	task automatic read_records(input int fd);
		logic [159:0]     tok;
		logic [7:0]       kind;
		logic [127:0]     code;
		logic [8*128-1:0] line;
		int               player;
		int               a;
		int               b;
		int               c;
		int               d;
		int               got;
		bit               done;
		done = 1'b0;
		while (!done) begin
			tok = '0;
			got = $fscanf(fd, "%s", tok);
			if (got != 1) begin
				done = 1'b1;
			end else if (tok[159:8] == '0 && tok[7:0] == "#") begin
				got = $fgets(line, fd);
			end else begin
				kind = '0;
				code = '0;
				player = 0;
				a = 0;
				b = 0;
				c = 0;
				d = 0;
				got = $fscanf(fd, "%s", kind);
				case (kind)
					"S": got = $fscanf(fd, "%d %s %d %b", player, code, a, b);
					"G": got = $fscanf(fd, "%d %s %d", player, code, b);
					"A": got = $fscanf(fd, "%d %d %d %d", a, b, c, d);
					default: got = $fgets(line, fd);
				endcase
				rec_name.push_back(tok);
				rec_kind.push_back(kind);
				rec_player.push_back(player);
				rec_code.push_back(code);
				rec_a.push_back(a);
				rec_b.push_back(b);
				rec_c.push_back(c);
				rec_d.push_back(d);
			end
		end
	endtask

	// Reset clears every player back to phase 00 and gear 1
	task automatic apply_reset();
		rst = 1'b1;
		repeat (4) @(posedge clk_12);
		#1;
		rst = 1'b0;
		for (int p = 0; p < sprint4_pkg::NUM_PLAYERS; p++) begin
			exp_phase[p] = 2'b00;
			exp_gear[p] = 1;
		end
	endtask

	task automatic hold_steer(input int p, input logic [7:0] dir, input int cycles);
		right[p] = (dir == "R" || dir == "B");
		left[p] = (dir == "L" || dir == "B");
		repeat (cycles) @(posedge clk_12);
		#1;
		right[p] = 1'b0;
		left[p] = 1'b0;
		// One released cycle clears the divide count before the next test
		@(posedge clk_12);
		#1;
	endtask

	// Each event holds its buttons for two cycles and then releases them for one
	// X presses both buttons together
	task automatic press_buttons(input int p, input logic [127:0] code);
		logic [7:0] ch;
		for (int k = 15; k >= 0; k--) begin
			ch = code[8*k +: 8];
			if (ch != 8'h00) begin
				gear_up[p] = (ch == "U" || ch == "X");
				gear_down[p] = (ch == "D" || ch == "X");
				// Only the rising edge of a longer press may move the gear
				repeat (2) @(posedge clk_12);
				#1;
				gear_up[p] = 1'b0;
				gear_down[p] = 1'b0;
				@(posedge clk_12);
				#1;
			end
		end
	endtask

	task automatic measure_dac(input int l, input int r, output int ones_l, output int ones_r);
		audio_l = sprint4_pkg::audio_t'(l);
		audio_r = sprint4_pkg::audio_t'(r);
		apply_reset();
		ones_l = 0;
		ones_r = 0;
		repeat (128) begin
			@(posedge clk_12);
			#1;
			if (audio_out_l)
				ones_l++;
			if (audio_out_r)
				ones_r++;
		end
	endtask

	task automatic check_value(input logic [159:0] name, input string what,
		input int expected, input int actual);
		assert (actual == expected) else begin
			$display("ERROR %0s %0s expected %0d actual %0d", name, what, expected, actual);
			test_errs++;
		end
	endtask

	task automatic check_players(input logic [159:0] name);
		sprint4_pkg::steer_phase_t act_phase;
		int                        act_gear;
		for (int p = 0; p < sprint4_pkg::NUM_PLAYERS; p++) begin
			act_phase = {steer_a[p], steer_b[p]};
			act_gear = gear_index({gear3[p], gear2[p], gear1[p]});
			assert (act_phase == exp_phase[p]) else begin
				$display("ERROR %0s player %0d phase expected %b actual %b",
					name, p, exp_phase[p], act_phase);
				test_errs++;
			end
			assert (act_gear == exp_gear[p]) else begin
				$display("ERROR %0s player %0d gear expected %0d actual %0d",
					name, p, exp_gear[p], act_gear);
				test_errs++;
			end
		end
	endtask

	task automatic run_tests();
		int ones_l;
		int ones_r;
		for (int i = 0; i < rec_name.size(); i++) begin
			test_errs = 0;
			if (rec_player[i] < 0 || rec_player[i] >= sprint4_pkg::NUM_PLAYERS) begin
				$display("Record %0s names a player that does not exist", rec_name[i]);
				test_errs++;
			end else begin
				case (rec_kind[i])
					"S": begin
						hold_steer(rec_player[i], rec_code[i][7:0], rec_a[i]);
						exp_phase[rec_player[i]] = sprint4_pkg::steer_phase_t'(rec_b[i]);
						check_players(rec_name[i]);
					end
					"G": begin
						press_buttons(rec_player[i], rec_code[i]);
						exp_gear[rec_player[i]] = rec_b[i];
						check_players(rec_name[i]);
					end
					"A": begin
						measure_dac(rec_a[i], rec_b[i], ones_l, ones_r);
						check_value(rec_name[i], "left ones", rec_c[i], ones_l);
						check_value(rec_name[i], "right ones", rec_d[i], ones_r);
						check_players(rec_name[i]);
					end
					default: begin
						$display("Record %0s has an unknown kind and was not run", rec_name[i]);
						test_errs++;
					end
				endcase
			end
			if (test_errs == 0) begin
				pass_count++;
				$display("Test %0s passed", rec_name[i]);
			end else begin
				fail_count++;
				$display("Test %0s failed with %0d mismatches", rec_name[i], test_errs);
			end
		end
	endtask

	task automatic watchdog(input int cycles);
		#(cycles * 8);
		$display("Watchdog expired after %0d cycles and the tests did not finish", cycles);
		$display("Errors found");
		$finish;
	endtask

	initial begin
		int fd;
		int limit_cycles;
		rst = 1'b1;
		right = '0;
		left = '0;
		gear_up = '0;
		gear_down = '0;
		audio_l = '0;
		audio_r = '0;
		pass_count = 0;
		fail_count = 0;
		fd = $fopen("controls_input.txt", "r");
		if (fd == 0) begin
			$display("Cannot open controls_input.txt for reading");
			$display("Errors found");
			$finish;
		end else begin
			read_records(fd);
			$fclose(fd);
			if (rec_name.size() == 0) begin
				$display("No test records were found in controls_input.txt");
				fail_count++;
			end
			limit_cycles = 200 + 4;
			for (int i = 0; i < rec_name.size(); i++)
				limit_cycles += record_cycles(i);
			fork
				watchdog(limit_cycles);
			join_none
			#1;
			apply_reset();
			run_tests();
			$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
			if (fail_count == 0)
				$display("No errors");
			else
				$display("Errors found");
			$finish;
		end
	end

endmodule
